// File: compile.f
hdl/piarb_pkg.sv
hdl/sync_fifo.sv
hdl/buf_prefetch.sv
hdl/pu_select.sv
hdl/pkt_writer.sv
hdl/piarb_enq.sv
sim/tb_piarb_enq.sv

// File: Bender.yml
package:
  name: piarb_enq

sources:
  - hdl/piarb_pkg.sv
  - hdl/sync_fifo.sv
  - hdl/buf_prefetch.sv
  - hdl/pu_select.sv
  - hdl/pkt_writer.sv
  - hdl/piarb_enq.sv
  - target: simulation
    files:
      - sim/tb_piarb_enq.sv

// File: sim/tb_piarb_enq.sv
`timescale 1ns/1ps
/*
 * Testbench for the arbiter enqueue stage. Sends random packets, acts as
 * buffer pool, flow table and PU queue, and checks writes and descriptors
 * against a model.
 */
module tb_piarb_enq;

localparam int NUM_PU   = piarb_pkg::NUM_PU_DEF;
localparam int NUM_PKTS = 200;
localparam int TIMEOUT  = 5000;

logic                         clk;
logic                         rst;
logic                         hop_valid;
piarb_pkg::hop_beat_t         hop_beat;
piarb_pkg::hop_meta_t         hop_meta;
logic                         hop_ready;
logic                         buf_req;
logic                         buf_ack;
logic [piarb_pkg::BPTR_W-1:0] buf_ptr;
logic                         fid_lookup_req;
logic [piarb_pkg::FID_W-1:0]  fid_lookup_fid;
logic                         fid_lookup_ack;
piarb_pkg::fid_status_t       fid_status [NUM_PU];
logic                         buf_wr_valid;
piarb_pkg::buf_write_t        buf_wr;
logic                         enq_req;
logic                         enq_ack;
piarb_pkg::enq_desc_t         enq_desc;

integer seed;

// Model queues of what the DUT must produce in arrival order.
piarb_pkg::hop_beat_t         beat_q [$];
piarb_pkg::hop_meta_t         meta_q [$];
int                           len_q [$];
logic [piarb_pkg::BPTR_W-1:0] pool_q [$];
logic [piarb_pkg::BPTR_W-1:0] first_q [$];
piarb_pkg::pu_choice_t        choice_q [$];

piarb_pkg::hop_beat_t         wr_beat;
logic [piarb_pkg::BPTR_W-1:0] next_ptr;
logic [piarb_pkg::BPTR_W-1:0] cur_ptr;
logic [piarb_pkg::BPTR_W-1:0] pkt_first;
int                           wr_lsb;
int                           lk_delay;
int                           pool_delay;
int                           enq_delay;
logic                         enq_seen;
int                           pkt_done;

piarb_enq #(
        .NUM_PU         (NUM_PU),
        .PREFETCH_DEPTH (8),
        .FIFO_DEPTH     (16)
) dut (
        .clk            (clk),
        .rst            (rst),
        .hop_valid      (hop_valid),
        .hop_beat       (hop_beat),
        .hop_meta       (hop_meta),
        .hop_ready      (hop_ready),
        .buf_req        (buf_req),
        .buf_ack        (buf_ack),
        .buf_ptr        (buf_ptr),
        .fid_lookup_req (fid_lookup_req),
        .fid_lookup_fid (fid_lookup_fid),
        .fid_lookup_ack (fid_lookup_ack),
        .fid_status     (fid_status),
        .buf_wr_valid   (buf_wr_valid),
        .buf_wr         (buf_wr),
        .enq_req        (enq_req),
        .enq_ack        (enq_ack),
        .enq_desc       (enq_desc)
);

initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
end

task automatic stop_run();
        $display("STATUS: FAIL");
        $fatal(1, "testbench stopped at the first error");
endtask

task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
        if (got !== exp) begin
                $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
                stop_run();
        end
endtask

task automatic expect_pending(input int count, input string what);
        if (count == 0) begin
                $display("The DUT produced a result but the model has no %s left", what);
                stop_run();
        end
endtask

function automatic piarb_pkg::fid_status_t random_status();
        logic [31:0]            r;
        piarb_pkg::fid_status_t st;
        r = $random(seed);
        st.valid = r[1:0];
        // Hits are rare so the idle and busy rules get exercised too.
        st.hit = r[3:2] & r[5:4] & r[7:6];
        return st;
endfunction

function automatic logic rule_matches(input int rule, input piarb_pkg::fid_status_t st);
        case (rule)
        0: return st.hit[0];
        1: return st.hit[1];
        2: return !st.valid[0];
        3: return !st.valid[1];
        4: return st.valid[0];
        default: return st.valid[1];
        endcase
endfunction

// Rules in priority order; the highest PU index wins within a rule.
function automatic piarb_pkg::pu_choice_t expected_choice();
        piarb_pkg::pu_choice_t c;
        c = '0;
        for (int rule = 0; rule < 6; rule++) begin
                for (int p = NUM_PU - 1; p >= 0; p--) begin
                        if (rule_matches(rule, fid_status[p])) begin
                                c.pu_id = p[piarb_pkg::PU_ID_W_DEF-1:0];
                                c.slot  = rule[0];
                                c.hit   = (rule < 2);
                                return c;
                        end
                end
        end
        return c;
endfunction

task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!hop_ready) begin
                if (cycles == TIMEOUT) begin
                        $display("Timed out waiting for hop_ready to rise");
                        stop_run();
                end else begin
                        @(negedge clk);
                        cycles++;
                end
        end
endtask

task automatic wait_packets_done();
        int cycles;
        cycles = 0;
        while (pkt_done < NUM_PKTS) begin
                if (cycles == TIMEOUT) begin
                        $display("Timed out waiting for all packets to be enqueued");
                        stop_run();
                end else begin
                        @(negedge clk);
                        cycles++;
                end
        end
endtask

task automatic send_packet();
        int                   len;
        logic [31:0]          r;
        piarb_pkg::hop_meta_t meta;
        piarb_pkg::hop_beat_t b;
        r = $random(seed);
        len = 1 + int'(r[7:0]) % 12;
        meta = r[31:16];
        for (int i = 0; i < len; i++) begin
                b.data[63:32] = $random(seed);
                b.data[31:0]  = $random(seed);
                b.sop         = (i == 0);
                b.eop         = (i == len - 1);
                hop_valid = 1'b1;
                hop_beat  = b;
                hop_meta  = meta;
                // Ready is stable until the next rising edge, which takes the beat.
                wait_ready();
                beat_q.push_back(b);
                if (b.sop) begin
                        meta_q.push_back(meta);
                        len_q.push_back(len);
                end
                @(negedge clk);
                hop_valid = 1'b0;
                r = $random(seed);
                if (r[1:0] == 2'b00) begin
                        @(negedge clk);
                end
        end
endtask

task automatic check_descriptor();
        piarb_pkg::hop_meta_t  m;
        piarb_pkg::pu_choice_t c;
        expect_pending(meta_q.size(), "packet metadata");
        expect_pending(first_q.size(), "first buffer pointer");
        expect_pending(choice_q.size(), "lookup result");
        m = meta_q.pop_front();
        c = choice_q.pop_front();
        check_value("enq_desc.len", enq_desc.len, len_q.pop_front());
        check_value("enq_desc.buf_ptr", enq_desc.buf_ptr, first_q.pop_front());
        check_value("enq_desc.fid", enq_desc.fid, m.fid);
        check_value("enq_desc.port", enq_desc.port, m.port);
        check_value("enq_desc.slot", enq_desc.slot, c.slot);
        check_value("enq_desc.fid_install", enq_desc.fid_install, !c.hit);
endtask

// Buffer pool handing out sequential pointers after a random delay.
always @(negedge clk) begin
        if (rst) begin
                buf_ack    = 1'b0;
                pool_delay = 0;
        end else if (buf_ack) begin
                if (!buf_req) begin
                        buf_ack = 1'b0;
                end
        end else if (buf_req) begin
                if (pool_delay > 0) begin
                        pool_delay--;
                end else begin
                        buf_ptr = next_ptr;
                        pool_q.push_back(next_ptr);
                        next_ptr   = next_ptr + 1'b1;
                        buf_ack    = 1'b1;
                        pool_delay = $unsigned($random(seed)) % 4;
                end
        end
end

// Flow table.
always @(negedge clk) begin
        if (rst) begin
                fid_lookup_ack = 1'b0;
                lk_delay       = 0;
        end else if (fid_lookup_ack) begin
                if (!fid_lookup_req) begin
                        fid_lookup_ack = 1'b0;
                end
        end else if (fid_lookup_req) begin
                if (lk_delay > 0) begin
                        lk_delay--;
                end else begin
                        expect_pending(meta_q.size(), "packet metadata");
                        check_value("fid_lookup_fid", fid_lookup_fid, meta_q[0].fid);
                        for (int p = 0; p < NUM_PU; p++) begin
                                fid_status[p] = random_status();
                        end
                        choice_q.push_back(expected_choice());
                        fid_lookup_ack = 1'b1;
                        lk_delay       = $unsigned($random(seed)) % 4;
                end
        end
end

// PU queue that acks 0 to 20 cycles after the request is seen.
always @(negedge clk) begin
        if (rst) begin
                enq_ack   = 1'b0;
                enq_seen  = 1'b0;
                enq_delay = 0;
        end else if (enq_ack) begin
                if (!enq_req) begin
                        enq_ack = 1'b0;
                end
        end else if (enq_req) begin
                if (!enq_seen) begin
                        check_descriptor();
                        enq_seen  = 1'b1;
                        enq_delay = $unsigned($random(seed)) % 21;
                end
                if (enq_delay > 0) begin
                        enq_delay--;
                end else begin
                        enq_ack  = 1'b1;
                        enq_seen = 1'b0;
                        pkt_done++;
                end
        end
end

// Buffer write monitor.
always @(negedge clk) begin
        if (!rst && buf_wr_valid) begin
                expect_pending(beat_q.size(), "beat");
                expect_pending(choice_q.size(), "lookup result");
                wr_beat = beat_q.pop_front();
                check_value("buf_wr.data", buf_wr.data, wr_beat.data);
                check_value("buf_wr.sop", buf_wr.sop, wr_beat.sop);
                check_value("buf_wr.lsb", buf_wr.lsb, wr_lsb);
                if (wr_lsb == 0) begin
                        expect_pending(pool_q.size(), "pool pointer");
                        cur_ptr = pool_q.pop_front();
                end
                check_value("buf_wr.buf_ptr", buf_wr.buf_ptr, cur_ptr);
                check_value("buf_wr.pu_id", buf_wr.pu_id, choice_q[0].pu_id);
                if (wr_beat.sop) begin
                        pkt_first = cur_ptr;
                end
                if (wr_beat.eop) begin
                        first_q.push_back(pkt_first);
                        wr_lsb = 0;
                end else begin
                        wr_lsb = (wr_lsb + 1) % 4;
                end
        end
end

initial begin
        logic [31:0] r;
        seed           = 32'h296c86a1;
        rst            = 1'b1;
        hop_valid      = 1'b0;
        hop_beat       = '0;
        hop_meta       = '0;
        buf_ack        = 1'b0;
        buf_ptr        = '0;
        fid_lookup_ack = 1'b0;
        enq_ack        = 1'b0;
        for (int p = 0; p < NUM_PU; p++) begin
                fid_status[p] = '0;
        end
        wr_lsb   = 0;
        pkt_done = 0;
        cur_ptr  = '0;
        r        = $random(seed);
        next_ptr = r[piarb_pkg::BPTR_W-1:0];
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("buf_req", buf_req, 0);
        check_value("fid_lookup_req", fid_lookup_req, 0);
        check_value("buf_wr_valid", buf_wr_valid, 0);
        check_value("enq_req", enq_req, 0);
        check_value("hop_ready", hop_ready, 1);
        for (int n = 0; n < NUM_PKTS; n++) begin
                send_packet();
        end
        hop_valid = 1'b0;
        wait_packets_done();
        check_value("beats left in model", beat_q.size(), 0);
        check_value("packets left in model", meta_q.size(), 0);
        check_value("lookups left in model", choice_q.size(), 0);
        $display("STATUS: PASS");
        $finish;
end

endmodule

// File: hdl/piarb_enq.sv
`timescale 1ns/1ps
/*
 * Arbiter enqueue stage. Buffers header beats and metadata, prefetches
 * free buffers, selects a PU per flow and enqueues one packet at a time.
 */
module piarb_enq #(
        parameter int NUM_PU         = piarb_pkg::NUM_PU_DEF,
        parameter int PREFETCH_DEPTH = 8,
        parameter int FIFO_DEPTH     = 16
) (
        input  logic                         clk,
        input  logic                         rst,
        input  logic                         hop_valid,
        input  piarb_pkg::hop_beat_t         hop_beat,
        input  piarb_pkg::hop_meta_t         hop_meta,
        output logic                         hop_ready,
        output logic                         buf_req,
        input  logic                         buf_ack,
        input  logic [piarb_pkg::BPTR_W-1:0] buf_ptr,
        output logic                         fid_lookup_req,
        output logic [piarb_pkg::FID_W-1:0]  fid_lookup_fid,
        input  logic                         fid_lookup_ack,
        input  piarb_pkg::fid_status_t       fid_status [NUM_PU],
        output logic                         buf_wr_valid,
        output piarb_pkg::buf_write_t        buf_wr,
        output logic                         enq_req,
        input  logic                         enq_ack,
        output piarb_pkg::enq_desc_t         enq_desc
);

logic                         hop_push;
logic                         beat_near_full;
logic                         meta_near_full;
piarb_pkg::hop_beat_t         fifo_beat;
logic                         beat_empty;
logic                         beat_rd;
piarb_pkg::hop_meta_t         fifo_meta;
logic                         meta_empty;
logic                         meta_rd;
logic                         lookup_start;
logic                         lookup_done;
piarb_pkg::pu_choice_t        choice;
logic                         ptr_avail;
logic [piarb_pkg::BPTR_W-1:0] ptr_head;
logic                         ptr_take;

assign hop_ready = !beat_near_full && !meta_near_full;
assign hop_push  = hop_valid && hop_ready;

sync_fifo #(
        .W     ($bits(piarb_pkg::hop_beat_t)),
        .DEPTH (FIFO_DEPTH)
) u_beat_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr        (hop_push),
        .din       (hop_beat),
        .rd        (beat_rd),
        .dout      (fifo_beat),
        .empty     (beat_empty),
        .near_full (beat_near_full)
);

// Metadata is pushed once per packet, with its sop beat.
sync_fifo #(
        .W     ($bits(piarb_pkg::hop_meta_t)),
        .DEPTH (FIFO_DEPTH / 2)
) u_meta_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr        (hop_push && hop_beat.sop),
        .din       (hop_meta),
        .rd        (meta_rd),
        .dout      (fifo_meta),
        .empty     (meta_empty),
        .near_full (meta_near_full)
);

buf_prefetch #(
        .PREFETCH_DEPTH (PREFETCH_DEPTH)
) u_buf_prefetch (
        .clk       (clk),
        .rst       (rst),
        .buf_req   (buf_req),
        .buf_ack   (buf_ack),
        .buf_ptr   (buf_ptr),
        .ptr_avail (ptr_avail),
        .ptr_head  (ptr_head),
        .ptr_take  (ptr_take)
);

pu_select #(
        .NUM_PU (NUM_PU)
) u_pu_select (
        .clk            (clk),
        .rst            (rst),
        .start          (lookup_start),
        .fid            (fifo_meta.fid),
        .fid_lookup_req (fid_lookup_req),
        .fid_lookup_fid (fid_lookup_fid),
        .fid_lookup_ack (fid_lookup_ack),
        .fid_status     (fid_status),
        .done           (lookup_done),
        .choice         (choice)
);

pkt_writer u_pkt_writer (
        .clk          (clk),
        .rst          (rst),
        .beat         (fifo_beat),
        .beat_empty   (beat_empty),
        .beat_rd      (beat_rd),
        .meta         (fifo_meta),
        .meta_empty   (meta_empty),
        .meta_rd      (meta_rd),
        .lookup_start (lookup_start),
        .lookup_done  (lookup_done),
        .choice       (choice),
        .ptr_avail    (ptr_avail),
        .ptr_head     (ptr_head),
        .ptr_take     (ptr_take),
        .buf_wr_valid (buf_wr_valid),
        .buf_wr       (buf_wr),
        .enq_req      (enq_req),
        .enq_ack      (enq_ack),
        .enq_desc     (enq_desc)
);

endmodule

// File: hdl/pkt_writer.sv
`timescale 1ns/1ps
/*
 * Packet writer FSM. Takes one packet through lookup, buffer writes of
 * four beats per buffer, and the queue enqueue handshake.
 */
module pkt_writer (
        input  logic                         clk,
        input  logic                         rst,
        input  piarb_pkg::hop_beat_t         beat,
        input  logic                         beat_empty,
        output logic                         beat_rd,
        input  piarb_pkg::hop_meta_t         meta,
        input  logic                         meta_empty,
        output logic                         meta_rd,
        output logic                         lookup_start,
        input  logic                         lookup_done,
        input  piarb_pkg::pu_choice_t        choice,
        input  logic                         ptr_avail,
        input  logic [piarb_pkg::BPTR_W-1:0] ptr_head,
        output logic                         ptr_take,
        output logic                         buf_wr_valid,
        output piarb_pkg::buf_write_t        buf_wr,
        output logic                         enq_req,
        input  logic                         enq_ack,
        output piarb_pkg::enq_desc_t         enq_desc
);

piarb_pkg::writer_state_t    state;
piarb_pkg::pu_choice_t       choice_q;
logic [piarb_pkg::LSB_W-1:0] lsb;
logic [piarb_pkg::LEN_W-1:0] len;
logic [piarb_pkg::BPTR_W-1:0] first_ptr;
logic                        fire;

assign lookup_start = (state == piarb_pkg::ST_IDLE) && !meta_empty;
assign fire         = (state == piarb_pkg::ST_WRITE) && !beat_empty && ptr_avail;
assign beat_rd      = fire;
// Buffer is used up after its fourth beat or at the end of the packet.
assign ptr_take     = fire && (lsb == '1 || beat.eop);
assign meta_rd      = fire && beat.eop;

always_ff @(posedge clk) begin
        if (rst) begin
                state        <= piarb_pkg::ST_IDLE;
                buf_wr_valid <= 1'b0;
                enq_req      <= 1'b0;
                lsb          <= '0;
                len          <= '0;
        end else begin
                buf_wr_valid <= fire;
                case (state)
                piarb_pkg::ST_IDLE: begin
                        if (lookup_start) begin
                                state <= piarb_pkg::ST_LOOKUP;
                        end
                end
                piarb_pkg::ST_LOOKUP: begin
                        if (lookup_done) begin
                                state <= piarb_pkg::ST_WRITE;
                                lsb   <= '0;
                                len   <= '0;
                        end
                end
                piarb_pkg::ST_WRITE: begin
                        if (fire) begin
                                lsb <= beat.eop ? '0 : lsb + 1'b1;
                                len <= len + 1'b1;
                                if (beat.eop) begin
                                        state <= piarb_pkg::ST_ENQ;
                                end
                        end
                end
                piarb_pkg::ST_ENQ: begin
                        if (!enq_req) begin
                                enq_req <= 1'b1;
                        end else if (enq_ack) begin
                                enq_req <= 1'b0;
                                state   <= piarb_pkg::ST_ENQ_END;
                        end
                end
                piarb_pkg::ST_ENQ_END: begin
                        if (!enq_ack) begin
                                state <= piarb_pkg::ST_IDLE;
                        end
                end
                default: state <= piarb_pkg::ST_IDLE;
                endcase
        end
end

always_ff @(posedge clk) begin
        if (lookup_done) begin
                choice_q <= choice;
        end
        if (fire) begin
                buf_wr.data    <= beat.data;
                buf_wr.buf_ptr <= ptr_head;
                buf_wr.lsb     <= lsb;
                buf_wr.pu_id   <= choice_q.pu_id;
                buf_wr.sop     <= beat.sop;
                if (len == '0) begin
                        first_ptr <= ptr_head;
                end
                if (beat.eop) begin
                        enq_desc.len         <= len + 1'b1;
                        enq_desc.buf_ptr     <= (len == '0) ? ptr_head : first_ptr;
                        enq_desc.fid         <= meta.fid;
                        enq_desc.port        <= meta.port;
                        enq_desc.slot        <= choice_q.slot;
                        enq_desc.fid_install <= !choice_q.hit;
                end
        end
end

a_sop_first: assert property (@(posedge clk) disable iff (rst)
        fire |-> (beat.sop == (len == '0)))
        else $error("sop out of place in packet");

endmodule

// File: hdl/pu_select.sv
`timescale 1ns/1ps
/*
 * PU selection. Runs one flow lookup per start and picks the PU and
 * slot by hit, then idle slot, then busy slot, highest PU index first.
 */
module pu_select #(
        parameter int NUM_PU = piarb_pkg::NUM_PU_DEF
) (
        input  logic                        clk,
        input  logic                        rst,
        input  logic                        start,
        input  logic [piarb_pkg::FID_W-1:0] fid,
        output logic                        fid_lookup_req,
        output logic [piarb_pkg::FID_W-1:0] fid_lookup_fid,
        input  logic                        fid_lookup_ack,
        input  piarb_pkg::fid_status_t      fid_status [NUM_PU],
        output logic                        done,
        output piarb_pkg::pu_choice_t       choice
);

localparam int ID_W = piarb_pkg::PU_ID_W_DEF;

logic [NUM_PU-1:0]     cand [6];
piarb_pkg::pu_choice_t sel;
logic                  found;
logic                  armed;

// Candidate masks in priority order with slot 0 before slot 1.
always_comb begin
        for (int i = 0; i < NUM_PU; i++) begin
                cand[0][i] = fid_status[i].hit[0];
                cand[1][i] = fid_status[i].hit[1];
                cand[2][i] = !fid_status[i].valid[0];
                cand[3][i] = !fid_status[i].valid[1];
                cand[4][i] = fid_status[i].valid[0];
                cand[5][i] = fid_status[i].valid[1];
        end
end

always_comb begin
        sel   = '0;
        found = 1'b0;
        for (int k = 0; k < 6; k++) begin
                if (!found && |cand[k]) begin
                        found     = 1'b1;
                        sel.slot  = (k % 2 == 1);
                        sel.hit   = (k < 2);
                        for (int i = 0; i < NUM_PU; i++) begin
                                if (cand[k][i]) begin
                                        sel.pu_id = ID_W'(i);
                                end
                        end
                end
        end
end

always_ff @(posedge clk) begin
        if (rst) begin
                fid_lookup_req <= 1'b0;
                armed          <= 1'b0;
                done           <= 1'b0;
        end else begin
                done <= fid_lookup_req && fid_lookup_ack;
                if (start) begin
                        armed <= 1'b1;
                end else if (fid_lookup_req) begin
                        armed <= 1'b0;
                end
                // A new request waits for the previous ack to fall.
                if (fid_lookup_req) begin
                        if (fid_lookup_ack) begin
                                fid_lookup_req <= 1'b0;
                        end
                end else if ((start || armed) && !fid_lookup_ack) begin
                        fid_lookup_req <= 1'b1;
                end
        end
end

always_ff @(posedge clk) begin
        if (start) begin
                fid_lookup_fid <= fid;
        end
        if (fid_lookup_req && fid_lookup_ack) begin
                choice <= sel;
        end
end

a_start_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> !(fid_lookup_req || armed))
        else $error("lookup started while one is in progress");

endmodule

// File: hdl/buf_prefetch.sv
`timescale 1ns/1ps
/*
 * Free buffer prefetcher. Keeps a stock of pool pointers topped up over
 * a four-phase req/ack handshake and presents the oldest one.
 */
module buf_prefetch #(
        parameter int PREFETCH_DEPTH = 8
) (
        input  logic                         clk,
        input  logic                         rst,
        output logic                         buf_req,
        input  logic                         buf_ack,
        input  logic [piarb_pkg::BPTR_W-1:0] buf_ptr,
        output logic                         ptr_avail,
        output logic [piarb_pkg::BPTR_W-1:0] ptr_head,
        input  logic                         ptr_take
);

localparam int CNT_W = $clog2(PREFETCH_DEPTH + 1);

logic [CNT_W-1:0] held;
logic             capture;
logic             stock_empty;

// Req drops right after ack, so req and ack together mark the ack edge.
assign capture   = buf_req && buf_ack;
assign ptr_avail = !stock_empty;

always_ff @(posedge clk) begin
        if (rst) begin
                buf_req <= 1'b0;
                held    <= '0;
        end else begin
                if (buf_req) begin
                        if (buf_ack) begin
                                buf_req <= 1'b0;
                        end
                end else if (!buf_ack && held < CNT_W'(PREFETCH_DEPTH)) begin
                        // At most one request outstanding.
                        buf_req <= 1'b1;
                end
                held <= held + CNT_W'(capture) - CNT_W'(ptr_take);
        end
end

sync_fifo #(
        .W     (piarb_pkg::BPTR_W),
        .DEPTH (PREFETCH_DEPTH)
) u_stock (
        .clk       (clk),
        .rst       (rst),
        .wr        (capture),
        .din       (buf_ptr),
        .rd        (ptr_take),
        .dout      (ptr_head),
        .empty     (stock_empty),
        .near_full ()
);

a_held_bound: assert property (@(posedge clk) disable iff (rst)
        held <= CNT_W'(PREFETCH_DEPTH))
        else $error("pointer stock above prefetch depth");

endmodule

// File: hdl/sync_fifo.sv
`timescale 1ns/1ps
/*
 * Synchronous show-ahead FIFO with an occupancy count.
 * near_full is set while two or fewer entries are free.
 */
module sync_fifo #(
        parameter int W     = 8,
        parameter int DEPTH = 16
) (
        input  logic         clk,
        input  logic         rst,
        input  logic         wr,
        input  logic [W-1:0] din,
        input  logic         rd,
        output logic [W-1:0] dout,
        output logic         empty,
        output logic         near_full
);

localparam int AW = $clog2(DEPTH);
localparam int CW = $clog2(DEPTH + 1);

logic [W-1:0]  mem [DEPTH];
logic [AW-1:0] wr_ptr;
logic [AW-1:0] rd_ptr;
logic [CW-1:0] count;

// Head entry is visible without a read.
assign dout      = mem[rd_ptr];
assign empty     = (count == '0);
assign near_full = (count >= CW'(DEPTH - 2));

always_ff @(posedge clk) begin
        if (wr) begin
                mem[wr_ptr] <= din;
        end
end

always_ff @(posedge clk) begin
        if (rst) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
        end else begin
                if (wr) begin
                        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                end
                if (rd) begin
                        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                end
                count <= count + CW'(wr) - CW'(rd);
        end
end

a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        wr |-> (count < CW'(DEPTH)))
        else $error("write to a full FIFO");

a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        rd |-> !empty)
        else $error("read from an empty FIFO");

endmodule

// File: hdl/piarb_pkg.sv
/*
 * Shared widths, beat/metadata/descriptor structs and the writer FSM
 * states of the arbiter enqueue stage.
 */
package piarb_pkg;

localparam int DATA_W      = 64;
localparam int FID_W       = 8;
localparam int BPTR_W      = 10;
localparam int LSB_W       = 2;
localparam int LEN_W       = 6;
localparam int NUM_PU_DEF  = 4;
localparam int PU_ID_W_DEF = 2;

typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              sop;
        logic              eop;
} hop_beat_t;

typedef struct packed {
        logic [FID_W-1:0] fid;
        logic [7:0]       port;
} hop_meta_t;

// One bit per flow slot.
typedef struct packed {
        logic [1:0] valid;
        logic [1:0] hit;
} fid_status_t;

typedef struct packed {
        logic [PU_ID_W_DEF-1:0] pu_id;
        logic                   slot;
        logic                   hit;
} pu_choice_t;

typedef struct packed {
        logic [DATA_W-1:0]      data;
        logic [BPTR_W-1:0]      buf_ptr;
        logic [LSB_W-1:0]       lsb;
        logic [PU_ID_W_DEF-1:0] pu_id;
        logic                   sop;
} buf_write_t;

typedef struct packed {
        logic [LEN_W-1:0]  len;
        logic [BPTR_W-1:0] buf_ptr;
        logic [FID_W-1:0]  fid;
        logic [7:0]        port;
        logic              slot;
        logic              fid_install;
} enq_desc_t;

typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITE,
        ST_ENQ,
        ST_ENQ_END
} writer_state_t;

endpackage
